//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = tb_calc
FILELIST = src.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^No errors$$"

clean:
	rm -rf obj_dir

//--- arith_unit.sv
`timescale 1ns/100ps

module arith_unit (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        alu_start,
	input  calc_pkg::alu_op_e           alu_op,
	input  logic [calc_pkg::opnd_w-1:0] op1,
	input  logic [calc_pkg::opnd_w-1:0] op2,
	output logic [disp_pkg::res_w-1:0]  result,
	output logic                        neg,
	output logic                        result_valid,
	output logic                        busy
);

	logic [disp_pkg::res_w-1:0] a_ext;
	logic [disp_pkg::res_w-1:0] b_ext;
	logic [disp_pkg::res_w-1:0] mcand; // shifts left
	logic [calc_pkg::opnd_w-1:0] mplier; // shifts right
	logic [3:0] bit_cnt;
	logic last_bit;

	assign a_ext = {{(disp_pkg::res_w - calc_pkg::opnd_w){1'b0}}, op1};
	assign b_ext = {{(disp_pkg::res_w - calc_pkg::opnd_w){1'b0}}, op2};
	assign last_bit = (bit_cnt == 4'(calc_pkg::opnd_w - 1));

	////////////////////////////////////////
	// control
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			result_valid <= 1'b0;
			bit_cnt <= '0;
		end
		else if (alu_start)
		begin
			busy <= (alu_op == calc_pkg::op_mul);
			result_valid <= (alu_op != calc_pkg::op_mul); // add/sub done now
			bit_cnt <= 4'd1; // bit 0 handled at start
		end
		else if (busy)
		begin
			bit_cnt <= bit_cnt + 4'd1;
			if (last_bit)
			begin
				busy <= 1'b0;
				result_valid <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// datapath, result doubles as accumulator
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (alu_start)
		begin
			mcand <= a_ext << 1;
			mplier <= op2 >> 1;
			case (alu_op)
				calc_pkg::op_add:
				begin
					result <= a_ext + b_ext;
					neg <= 1'b0;
				end
				calc_pkg::op_sub:
				begin
					if (op1 < op2)
					begin
						result <= b_ext - a_ext; // magnitude only
						neg <= 1'b1;
					end
					else
					begin
						result <= a_ext - b_ext;
						neg <= 1'b0;
					end
				end
				default:
				begin
					result <= op2[0] ? a_ext : '0; // first partial product
					neg <= 1'b0;
				end
			endcase
		end
		else if (busy)
		begin
			if (mplier[0])
				result <= result + mcand;
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	// add/sub one edge later, multiply opnd_w edges later
	a_valid_after_start : assert property (@(posedge clk) disable iff (!rst_n)
		$rose(result_valid) |-> $past(alu_start, 1) || $past(alu_start, calc_pkg::opnd_w))
		else $error("result_valid rose without alu_start");

endmodule

//--- bcd_display.sv
`timescale 1ns/100ps

module bcd_display (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        num_enable1,
	input  logic                        num_enable2,
	input  logic                        ans_enable,
	input  logic [calc_pkg::opnd_w-1:0] op1,
	input  logic [calc_pkg::opnd_w-1:0] op2,
	input  logic [disp_pkg::res_w-1:0]  result,
	input  logic                        neg,
	input  logic                        result_valid,
	output logic [disp_pkg::num_digits*disp_pkg::digit_w-1:0] digits,
	output logic                        digit_neg,
	output logic                        disp_valid
);

	logic [disp_pkg::res_w-1:0] sel_val;
	logic [disp_pkg::res_w-1:0] snap_val;
	logic [disp_pkg::res_w-1:0] sh; // binary bits still to shift in
	logic [2:0] sel;
	logic [2:0] snap_sel;
	logic sel_neg;
	logic snap_neg;
	logic conv_busy;
	logic [4:0] shift_cnt;
	logic match;

	// add 3 to every digit of 5 or more before the shift
	function automatic logic [disp_pkg::num_digits*disp_pkg::digit_w-1:0] add3(
		input logic [disp_pkg::num_digits*disp_pkg::digit_w-1:0] b);
		logic [disp_pkg::num_digits*disp_pkg::digit_w-1:0] r;
		r = b;
		for (int i = 0; i < disp_pkg::num_digits; i++)
			if (r[i*disp_pkg::digit_w +: disp_pkg::digit_w] >= 4'd5)
				r[i*disp_pkg::digit_w +: disp_pkg::digit_w] =
					r[i*disp_pkg::digit_w +: disp_pkg::digit_w] + 4'd3;
		return r;
	endfunction

	assign sel = {ans_enable, num_enable2, num_enable1};
	assign sel_neg = ans_enable & neg; // operands are never negative

	always_comb
		if (ans_enable)
			sel_val = result;
		else if (num_enable2)
			sel_val = {{(disp_pkg::res_w - calc_pkg::opnd_w){1'b0}}, op2};
		else
			sel_val = {{(disp_pkg::res_w - calc_pkg::opnd_w){1'b0}}, op1};

	assign match = (sel == snap_sel) && (sel_val == snap_val) && (sel_neg == snap_neg);
	assign disp_valid = !conv_busy && match && (!ans_enable || result_valid);
	assign digit_neg = snap_neg;

	////////////////////////////////////////
	// double dabble, one bit per cycle
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			snap_sel <= '0; // forces a first conversion
			snap_val <= '0;
			snap_neg <= 1'b0;
			sh <= '0;
			digits <= '0;
			shift_cnt <= '0;
			conv_busy <= 1'b0;
		end
		else if (!conv_busy)
		begin
			if (!match) // load cycle
			begin
				snap_sel <= sel;
				snap_val <= sel_val;
				snap_neg <= sel_neg;
				sh <= sel_val;
				digits <= '0;
				shift_cnt <= '0;
				conv_busy <= 1'b1;
			end
		end
		else
		begin
			{digits, sh} <= {add3(digits), sh} << 1;
			shift_cnt <= shift_cnt + 5'd1;
			if (shift_cnt == 5'(disp_pkg::res_w - 1))
				conv_busy <= 1'b0;
		end
	end

endmodule

//--- calc_fsm.sv
`timescale 1ns/100ps

module calc_fsm (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              key_valid,
	input  logic [3:0]        key,
	output logic              num_enable1,
	output logic              num_enable2,
	output logic              ans_enable,
	output logic              alu_start,
	output calc_pkg::alu_op_e alu_op,
	output logic              clear
);

	calc_pkg::calc_state_e state;
	calc_pkg::calc_state_e next_state;
	calc_pkg::calc_state_e op_state; // right state picked by an operator key
	calc_pkg::calc_state_e eq_state; // equals state for the current operator
	logic is_op;

	assign is_op = (key == calc_pkg::key_add) || (key == calc_pkg::key_sub) ||
		(key == calc_pkg::key_mul);

	always_comb
	begin
		if (key == calc_pkg::key_add)
			op_state = calc_pkg::st_right_add;
		else if (key == calc_pkg::key_sub)
			op_state = calc_pkg::st_right_sub;
		else
			op_state = calc_pkg::st_right_mul;

		if (state == calc_pkg::st_right_add)
			eq_state = calc_pkg::st_eq_add;
		else if (state == calc_pkg::st_right_sub)
			eq_state = calc_pkg::st_eq_sub;
		else
			eq_state = calc_pkg::st_eq_mul;
	end

	////////////////////////////////////////
	// transitions, only on an accepted key
	////////////////////////////////////////

	always_comb
	begin
		next_state = state;
		if (key_valid)
		begin
			if (key == calc_pkg::key_clr)
				next_state = calc_pkg::st_left; // from anywhere
			else
				case (state)
					calc_pkg::st_left:
						if (is_op)
							next_state = op_state;
					calc_pkg::st_right_add, calc_pkg::st_right_sub, calc_pkg::st_right_mul:
						if (is_op)
							next_state = op_state; // last operator wins
						else if (key == calc_pkg::key_eq)
							next_state = eq_state;
					calc_pkg::st_eq_add, calc_pkg::st_eq_sub, calc_pkg::st_eq_mul:
						next_state = state; // answer held until clear
					default:
						next_state = calc_pkg::st_left;
				endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n)
		if (!rst_n)
			state <= calc_pkg::st_left;
		else
			state <= next_state;

	////////////////////////////////////////
	// decoded outputs
	////////////////////////////////////////

	assign num_enable1 = (state == calc_pkg::st_left);
	assign num_enable2 = (state == calc_pkg::st_right_add) ||
		(state == calc_pkg::st_right_sub) || (state == calc_pkg::st_right_mul);
	assign ans_enable = (state == calc_pkg::st_eq_add) ||
		(state == calc_pkg::st_eq_sub) || (state == calc_pkg::st_eq_mul);

	always_comb
		case (state)
			calc_pkg::st_right_sub, calc_pkg::st_eq_sub: alu_op = calc_pkg::op_sub;
			calc_pkg::st_right_mul, calc_pkg::st_eq_mul: alu_op = calc_pkg::op_mul;
			default: alu_op = calc_pkg::op_add;
		endcase

	// ALU latches on the edge we enter the equals state
	assign alu_start = key_valid && (key == calc_pkg::key_eq) && num_enable2;
	assign clear = key_valid && (key == calc_pkg::key_clr);

	a_one_enable : assert property (@(posedge clk) disable iff (!rst_n)
		$onehot({num_enable1, num_enable2, ans_enable}))
		else $error("enables not one-hot");

endmodule

//--- calc_pkg.sv
package calc_pkg;

	////////////////////////////////////////
	// operand sizing
	////////////////////////////////////////

	localparam int opnd_w     = 14; // holds 9999
	localparam int max_digits = 4;

	////////////////////////////////////////
	// keypad codes, 0..9 are digits
	////////////////////////////////////////

	localparam logic [3:0] key_add = 4'd10;
	localparam logic [3:0] key_sub = 4'd11;
	localparam logic [3:0] key_clr = 4'd12;
	localparam logic [3:0] key_mul = 4'd13;
	localparam logic [3:0] key_eq  = 4'd14; // 15 is ignored

	// operator FSM states
	typedef enum logic [2:0] {
		st_left      = 3'd0, // first operand
		st_right_add = 3'd1,
		st_right_sub = 3'd2,
		st_right_mul = 3'd3,
		st_eq_add    = 3'd4, // answer on show
		st_eq_sub    = 3'd5,
		st_eq_mul    = 3'd6
	} calc_state_e;

	typedef enum logic [1:0] {
		op_add,
		op_sub,
		op_mul
	} alu_op_e;

endpackage

//--- calc_top.sv
`timescale 1ns/100ps

module calc_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        key_req,
	input  logic [3:0]  key_code,
	output logic        key_ack,
	output logic [31:0] digits,
	output logic        digit_neg,
	output logic        disp_valid
);

	logic key_valid;
	logic [3:0] key;
	logic num_enable1;
	logic num_enable2;
	logic ans_enable;
	logic alu_start;
	calc_pkg::alu_op_e alu_op;
	logic clear;
	logic [calc_pkg::opnd_w-1:0] op1;
	logic [calc_pkg::opnd_w-1:0] op2;
	logic [disp_pkg::res_w-1:0] result;
	logic neg;
	logic result_valid;
	logic busy;

	////////////////////////////////////////
	// keypad -> fsm/operands -> alu -> display
	////////////////////////////////////////

	key_intake u_intake (
		.clk       (clk),
		.rst_n     (rst_n),
		.key_req   (key_req),
		.key_code  (key_code),
		.busy      (busy),
		.key_ack   (key_ack),
		.key_valid (key_valid),
		.key       (key)
	);

	calc_fsm u_fsm (
		.clk         (clk),
		.rst_n       (rst_n),
		.key_valid   (key_valid),
		.key         (key),
		.num_enable1 (num_enable1),
		.num_enable2 (num_enable2),
		.ans_enable  (ans_enable),
		.alu_start   (alu_start),
		.alu_op      (alu_op),
		.clear       (clear)
	);

	operand_entry u_entry (
		.clk         (clk),
		.rst_n       (rst_n),
		.key_valid   (key_valid),
		.key         (key),
		.num_enable1 (num_enable1),
		.num_enable2 (num_enable2),
		.clear       (clear),
		.op1         (op1),
		.op2         (op2)
	);

	arith_unit u_alu (
		.clk          (clk),
		.rst_n        (rst_n),
		.alu_start    (alu_start),
		.alu_op       (alu_op),
		.op1          (op1),
		.op2          (op2),
		.result       (result),
		.neg          (neg),
		.result_valid (result_valid),
		.busy         (busy)
	);

	bcd_display u_disp (
		.clk          (clk),
		.rst_n        (rst_n),
		.num_enable1  (num_enable1),
		.num_enable2  (num_enable2),
		.ans_enable   (ans_enable),
		.op1          (op1),
		.op2          (op2),
		.result       (result),
		.neg          (neg),
		.result_valid (result_valid),
		.digits       (digits),
		.digit_neg    (digit_neg),
		.disp_valid   (disp_valid)
	);

endmodule

//--- disp_pkg.sv
package disp_pkg;

	// answer magnitude, 9999 * 9999 needs 27 bits
	localparam int res_w = 27;

	// BCD readout
	localparam int num_digits = 8;
	localparam int digit_w    = 4;

endpackage

//--- key_intake.sv
`timescale 1ns/100ps

module key_intake (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       key_req,
	input  logic [3:0] key_code,
	input  logic       busy,
	output logic       key_ack,
	output logic       key_valid,
	output logic [3:0] key
);

	typedef enum logic {
		hs_idle,
		hs_ack
	} hs_state_e;

	hs_state_e state;
	logic accept;

	// no new key while the multiplier runs
	assign accept = (state == hs_idle) && key_req && !busy;
	assign key_ack = (state == hs_ack);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= hs_idle;
			key_valid <= 1'b0;
		end
		else
		begin
			key_valid <= accept; // one cycle per key
			case (state)
				hs_idle:
					if (accept)
						state <= hs_ack;
				hs_ack:
					if (!key_req) // source released, drop ack
						state <= hs_idle;
				default:
					state <= hs_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
		if (accept)
			key <= key_code;

	a_ack_needs_req : assert property (@(posedge clk) disable iff (!rst_n)
		$rose(key_ack) |-> $past(key_req))
		else $error("key_ack rose without key_req");

endmodule

//--- operand_entry.sv
`timescale 1ns/100ps

module operand_entry (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        key_valid,
	input  logic [3:0]                  key,
	input  logic                        num_enable1,
	input  logic                        num_enable2,
	input  logic                        clear,
	output logic [calc_pkg::opnd_w-1:0] op1,
	output logic [calc_pkg::opnd_w-1:0] op2
);

	logic [calc_pkg::opnd_w-1:0] opnd [2];
	logic [2:0] cnt [2]; // digits taken so far
	logic [1:0] en;
	logic is_digit;

	assign en = {num_enable2, num_enable1};
	assign is_digit = (key <= 4'd9);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 2; i++)
			begin
				opnd[i] <= '0;
				cnt[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < 2; i++)
			begin
				if (clear)
				begin
					opnd[i] <= '0;
					cnt[i] <= '0;
				end
				else if (key_valid && is_digit && en[i] &&
					cnt[i] != 3'(calc_pkg::max_digits))
				begin
					// x*10 as x*8 + x*2
					opnd[i] <= (opnd[i] << 3) + (opnd[i] << 1) +
						{{(calc_pkg::opnd_w - 4){1'b0}}, key};
					cnt[i] <= cnt[i] + 3'd1;
				end
			end
		end
	end

	assign op1 = opnd[0];
	assign op2 = opnd[1];

endmodule

//--- src.f
calc_pkg.sv
disp_pkg.sv
key_intake.sv
calc_fsm.sv
operand_entry.sv
arith_unit.sv
bcd_display.sv
calc_top.sv
tb_clock.sv
tb_calc.sv

//--- tb_calc.sv
`timescale 1ns/100ps

module tb_calc;

	localparam int n_tests        = 5;
	localparam int keys_per_test  = 40;
	localparam int cycles_per_key = 60;
	localparam int cycle_limit    = 2 * n_tests * keys_per_test * cycles_per_key;
	localparam logic [15:0] lfsr_seed = 16'd64615;

	logic clk;
	logic rst_n;
	logic key_req;
	logic [3:0] key_code;
	logic key_ack;
	logic [31:0] digits;
	logic digit_neg;
	logic disp_valid;

	int m_mode; // 0 operand 1, 1 operand 2, 2 answer
	logic [3:0] m_op;
	int m_op1;
	int m_op2;
	int m_cnt1;
	int m_cnt2;
	int m_res;
	logic m_neg;
	logic [31:0] exp_digits;
	logic exp_neg;
	logic chk_en; // low while a key is in flight
	logic [15:0] lfsr;
	int errors;
	int checks;
	int cycles;
	int tests_done;
	int err_mark;

	tb_clock clk_gen (.clk (clk), .rst_n (rst_n));

	calc_top dut0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.key_req    (key_req),
		.key_code   (key_code),
		.key_ack    (key_ack),
		.digits     (digits),
		.digit_neg  (digit_neg),
		.disp_valid (disp_valid)
	);

	////////////////////////////////////////
	// random digits and reference model
	////////////////////////////////////////

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10]; // x^16 + x^14 + x^13 + x^11 + 1
		return {s[14:0], fb};
	endfunction

	function automatic int rand_bits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			r = (r << 1) | int'(lfsr[0]);
		end
		return r;
	endfunction

	function automatic logic [3:0] pick_operator();
		case (rand_bits(2) % 3)
			0: return calc_pkg::key_add;
			1: return calc_pkg::key_sub;
			default: return calc_pkg::key_mul;
		endcase
	endfunction

	// decimal digits, least significant in the low nibble
	function automatic logic [31:0] to_bcd(input int v);
		logic [31:0] r;
		int rest;
		rest = v;
		for (int i = 0; i < 8; i++)
		begin
			r[i*4 +: 4] = 4'(rest % 10);
			rest = rest / 10;
		end
		return r;
	endfunction

	task automatic apply_model(input logic [3:0] k);
		int shown;
		if (k == calc_pkg::key_clr)
		begin
			m_mode = 0;
			m_op = calc_pkg::key_add;
			m_op1 = 0;
			m_op2 = 0;
			m_cnt1 = 0;
			m_cnt2 = 0;
		end
		else if (k <= 4'd9)
		begin
			if (m_mode == 0 && m_cnt1 < calc_pkg::max_digits)
			begin
				m_op1 = m_op1 * 10 + int'(k);
				m_cnt1++;
			end
			else if (m_mode == 1 && m_cnt2 < calc_pkg::max_digits)
			begin
				m_op2 = m_op2 * 10 + int'(k);
				m_cnt2++;
			end
		end
		else if (k == calc_pkg::key_add || k == calc_pkg::key_sub || k == calc_pkg::key_mul)
		begin
			if (m_mode != 2) // answer ignores operators
			begin
				m_mode = 1;
				m_op = k;
			end
		end
		else if (k == calc_pkg::key_eq && m_mode == 1)
		begin
			m_mode = 2;
			m_neg = 1'b0;
			if (m_op == calc_pkg::key_add)
				m_res = m_op1 + m_op2;
			else if (m_op == calc_pkg::key_mul)
				m_res = m_op1 * m_op2;
			else if (m_op1 < m_op2)
			begin
				m_res = m_op2 - m_op1;
				m_neg = 1'b1;
			end
			else
				m_res = m_op1 - m_op2;
		end
		shown = (m_mode == 0) ? m_op1 : (m_mode == 1) ? m_op2 : m_res;
		exp_digits = to_bcd(shown);
		exp_neg = (m_mode == 2) && m_neg;
	endtask

	////////////////////////////////////////
	// keypad side
	////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic handshake(input logic [3:0] k);
		key_code = k;
		key_req = 1'b1;
		while (key_ack !== 1'b1)
			next_cycle();
		key_req = 1'b0;
		while (key_ack !== 1'b0)
			next_cycle();
	endtask

	task automatic wait_display();
		while (disp_valid !== 1'b1)
			next_cycle();
		next_cycle(); // one sampling edge with valid high
		checks++;
	endtask

	task automatic press(input logic [3:0] k);
		chk_en = 1'b0;
		handshake(k);
		apply_model(k);
		chk_en = 1'b1;
		wait_display();
	endtask

	task automatic enter_number(input int n);
		for (int i = 0; i < n; i++)
			press(4'(rand_bits(4) % 10));
	endtask

	task automatic calculate(input logic [3:0] op, input int n1, input int n2);
		press(calc_pkg::key_clr);
		enter_number(n1);
		press(op);
		enter_number(n2);
		press(calc_pkg::key_eq);
	endtask

	task automatic finish_test(input string name);
		tests_done++;
		$display("test %0d (%s) finished with %0d errors", tests_done, name, errors - err_mark);
		err_mark = errors;
	endtask

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	a_ack_rise : assert property (@(posedge clk) disable iff (!rst_n)
		$rose(key_ack) |-> $past(key_req))
		else
		begin
			$display("key_ack rose while key_req was low");
			errors++;
		end

	a_ack_fall : assert property (@(posedge clk) disable iff (!rst_n)
		$fell(key_ack) |-> !$past(key_req))
		else
		begin
			$display("key_ack fell while key_req was still high");
			errors++;
		end

	// a key sent during a multiply waits for the product
	a_hold_off : assert property (@(posedge clk) disable iff (!rst_n)
		$rose(key_ack) && dut0.ans_enable |-> dut0.result_valid)
		else
		begin
			$display("key acknowledged before the product was ready");
			errors++;
		end

	a_digits : assert property (@(posedge clk) disable iff (!rst_n)
		disp_valid && chk_en |-> digits == exp_digits)
		else
		begin
			$display("FAILED digits: got %h expected %h", $sampled(digits), $sampled(exp_digits));
			errors++;
		end

	a_sign : assert property (@(posedge clk) disable iff (!rst_n)
		disp_valid && chk_en |-> digit_neg == exp_neg)
		else
		begin
			$display("FAILED digit_neg: got %h expected %h", $sampled(digit_neg),
				$sampled(exp_neg));
			errors++;
		end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("Errors found");
			$finish;
		end
	end

	initial
	begin
		key_req = 1'b0;
		key_code = 4'd0;
		chk_en = 1'b0;
		lfsr = lfsr_seed;
		errors = 0;
		checks = 0;
		cycles = 0;
		tests_done = 0;
		err_mark = 0;
		apply_model(calc_pkg::key_clr); // power-up shows zero
		wait (rst_n === 1'b1);
		next_cycle();
		chk_en = 1'b1;
		wait_display();

		// handshake, plus a key held off by the multiplier
		press(calc_pkg::key_clr);
		enter_number(3);
		press(calc_pkg::key_mul);
		enter_number(3);
		chk_en = 1'b0;
		handshake(calc_pkg::key_eq);
		apply_model(calc_pkg::key_eq);
		press(4'(rand_bits(4) % 10));
		press(calc_pkg::key_clr);
		finish_test("handshake");

		press(calc_pkg::key_clr);
		enter_number(6); // last two dropped
		press(calc_pkg::key_add);
		enter_number(6);
		press(calc_pkg::key_clr);
		finish_test("digit entry");

		calculate(calc_pkg::key_add, 3, 3);
		calculate(calc_pkg::key_sub, 3, 3);
		calculate(calc_pkg::key_mul, 3, 3);
		press(calc_pkg::key_clr);
		enter_number(1);
		press(calc_pkg::key_sub);
		press(4'd9); // op2 above 9000, so negative
		enter_number(3);
		press(calc_pkg::key_eq);
		finish_test("arithmetic");

		for (int round = 0; round < 2; round++)
		begin
			press(calc_pkg::key_clr);
			enter_number(2);
			repeat (4) press(pick_operator());
			enter_number(2);
			press(calc_pkg::key_eq);
		end
		finish_test("last operator");

		calculate(calc_pkg::key_sub, 3, 3);
		press(4'(rand_bits(4) % 10));
		press(calc_pkg::key_add);
		press(calc_pkg::key_mul);
		press(calc_pkg::key_eq);
		press(4'hf);
		press(calc_pkg::key_clr);
		enter_number(2);
		finish_test("answer hold");

		$display("tests: %0d  display checks: %0d  errors: %0d", tests_done, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	localparam int reset_cycles = 10;

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1 rst_n = 1'b1; // release away from the edge
	end

endmodule
